// ==== filelist.f ====
rtl/ecc_pkg.sv
rtl/ecc_43_cal.sv
rtl/ecc_write_encoder.sv
rtl/ecc_word_buffer.sv
rtl/ecc_read_corrector.sv
rtl/ecc_buffer_top.sv
verif/ecc_buffer_properties.sv
verif/ecc_buffer_tb.sv

// ==== rtl/ecc_43_cal.sv ====
`timescale 1ns/1ns

module ecc_43_cal (
    input  logic [ecc_pkg::DATA_WIDTH-1:0]   data_in,
    input  logic [ecc_pkg::PARITY_WIDTH-1:0] parity_in,
    input  logic                             bypass,
    output logic [ecc_pkg::DATA_WIDTH-1:0]   data_out,
    output logic                             sbit_err,
    output logic                             dbit_err
);
    import ecc_pkg::*;

    logic [PARITY_WIDTH-1:0] syndrome;
    logic [DATA_WIDTH-1:0]   mask;
    logic                    single_err;
    logic                    double_err;

    assign syndrome = parity_in ^ ecc_encode(data_in);

    // one column of H per data bit; a match points at the bit to flip.
    always_comb begin
        mask = '0;
        case (syndrome)
            7'b1000011: mask[0]  = 1'b1;
            7'b1000101: mask[1]  = 1'b1;
            7'b1000110: mask[2]  = 1'b1;
            7'b0000111: mask[3]  = 1'b1;
            7'b1001001: mask[4]  = 1'b1;
            7'b1001010: mask[5]  = 1'b1;
            7'b0001011: mask[6]  = 1'b1;
            7'b1001100: mask[7]  = 1'b1;
            7'b0001101: mask[8]  = 1'b1;
            7'b0001110: mask[9]  = 1'b1;
            7'b1001111: mask[10] = 1'b1;
            7'b1010001: mask[11] = 1'b1;
            7'b1010010: mask[12] = 1'b1;
            7'b0010011: mask[13] = 1'b1;
            7'b1010100: mask[14] = 1'b1;
            7'b0010101: mask[15] = 1'b1;
            7'b0010110: mask[16] = 1'b1;
            7'b1010111: mask[17] = 1'b1;
            7'b1011000: mask[18] = 1'b1;
            7'b0011001: mask[19] = 1'b1;
            7'b0011010: mask[20] = 1'b1;
            7'b1011011: mask[21] = 1'b1;
            7'b0011100: mask[22] = 1'b1;
            7'b1011101: mask[23] = 1'b1;
            7'b1011110: mask[24] = 1'b1;
            7'b0011111: mask[25] = 1'b1;
            7'b1100001: mask[26] = 1'b1;
            7'b1100010: mask[27] = 1'b1;
            7'b0100011: mask[28] = 1'b1;
            7'b1100100: mask[29] = 1'b1;
            7'b0100101: mask[30] = 1'b1;
            7'b0100110: mask[31] = 1'b1;
            7'b1100111: mask[32] = 1'b1;
            7'b1101000: mask[33] = 1'b1;
            7'b0101001: mask[34] = 1'b1;
            7'b0101010: mask[35] = 1'b1;
            7'b1101011: mask[36] = 1'b1;
            7'b0101100: mask[37] = 1'b1;
            7'b1101101: mask[38] = 1'b1;
            7'b1101110: mask[39] = 1'b1;
            7'b0101111: mask[40] = 1'b1;
            7'b1110000: mask[41] = 1'b1;
            7'b0110001: mask[42] = 1'b1;
            default:    mask     = '0;
        endcase
    end

    // weight one means a flipped check bit, data is already good.
    assign single_err = (|mask) || ($countones(syndrome) == 1);
    assign double_err = (syndrome != '0) && !single_err;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = !bypass && single_err;
    assign dbit_err = !bypass && double_err;

endmodule

// ==== rtl/ecc_buffer_top.sv ====
`timescale 1ns/1ns

module ecc_buffer_top (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic [ecc_pkg::DATA_WIDTH-1:0] in_data,
    input  logic [ecc_pkg::CODE_WIDTH-1:0] in_flip,
    output logic                           in_credit,
    input  logic                           out_credit,
    input  logic                           bypass,
    output logic                           out_valid,
    output logic [ecc_pkg::DATA_WIDTH-1:0] out_data,
    output logic                           out_sbit_err,
    output logic                           out_dbit_err
);
    import ecc_pkg::*;

    logic      wr_valid;
    ecc_word_t wr_word;
    logic      rd_avail;
    logic      rd_pop;
    ecc_word_t rd_word;

    ecc_write_encoder i_ecc_write_encoder (
        .clk      (clk),
        .reset    (reset),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_flip  (in_flip),
        .wr_valid (wr_valid),
        .wr_word  (wr_word)
    );

    ecc_word_buffer i_ecc_word_buffer (
        .clk       (clk),
        .reset     (reset),
        .wr_valid  (wr_valid),
        .wr_word   (wr_word),
        .rd_pop    (rd_pop),
        .rd_avail  (rd_avail),
        .rd_word   (rd_word),
        .in_credit (in_credit)
    );

    ecc_read_corrector i_ecc_read_corrector (
        .clk          (clk),
        .reset        (reset),
        .rd_avail     (rd_avail),
        .rd_word      (rd_word),
        .out_credit   (out_credit),
        .bypass       (bypass),
        .rd_pop       (rd_pop),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_sbit_err (out_sbit_err),
        .out_dbit_err (out_dbit_err)
    );

endmodule

// ==== rtl/ecc_pkg.sv ====
package ecc_pkg;

    localparam int DATA_WIDTH   = 43;
    localparam int PARITY_WIDTH = 7;
    localparam int CODE_WIDTH   = DATA_WIDTH + PARITY_WIDTH;

    localparam int BUF_DEPTH    = 8;
    localparam int OUT_CREDITS  = 4;

    localparam int PTR_WIDTH    = $clog2(BUF_DEPTH);
    localparam int COUNT_WIDTH  = $clog2(BUF_DEPTH + 1);
    localparam int CREDIT_WIDTH = $clog2(OUT_CREDITS + 1);

    // data bits covered by each check bit, one row of H per entry.
    localparam logic [DATA_WIDTH-1:0] PARITY_MASK [PARITY_WIDTH] = '{
        43'h555_56aa_ad5b,
        43'h199_9b33_366d,
        43'h1e1_e3c3_c78e,
        43'h1fe_03fc_07f0,
        43'h600_03ff_f800,
        43'h7ff_fc00_0000,
        43'h2d3_2da6_5cb7
    };

    typedef struct packed {
        logic [PARITY_WIDTH-1:0] parity;
        logic [DATA_WIDTH-1:0]   data;
    } ecc_fields_t;

    // flat view for error injection, field view for decoding.
    typedef union packed {
        logic [CODE_WIDTH-1:0] bits;
        ecc_fields_t           fields;
    } ecc_word_t;

    function automatic logic [PARITY_WIDTH-1:0] ecc_encode(input logic [DATA_WIDTH-1:0] data);
        logic [PARITY_WIDTH-1:0] parity;
        for (int i = 0; i < PARITY_WIDTH; i++) begin
            parity[i] = ^(data & PARITY_MASK[i]);
        end
        return parity;
    endfunction

endpackage

// ==== rtl/ecc_read_corrector.sv ====
`timescale 1ns/1ns

module ecc_read_corrector (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           rd_avail,
    input  ecc_pkg::ecc_word_t             rd_word,
    input  logic                           out_credit,
    input  logic                           bypass,
    output logic                           rd_pop,
    output logic                           out_valid,
    output logic [ecc_pkg::DATA_WIDTH-1:0] out_data,
    output logic                           out_sbit_err,
    output logic                           out_dbit_err
);
    import ecc_pkg::*;

    logic [CREDIT_WIDTH-1:0] credit_cnt;
    logic [DATA_WIDTH-1:0]   cal_data;
    logic                    cal_sbit_err;
    logic                    cal_dbit_err;

    // the credit is spent at the pop, so a word in flight is already paid for.
    assign rd_pop = rd_avail && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            credit_cnt <= CREDIT_WIDTH'(OUT_CREDITS);
        end else begin
            case ({out_credit, rd_pop})
                2'b10: begin
                    if (credit_cnt != CREDIT_WIDTH'(OUT_CREDITS)) begin
                        credit_cnt <= credit_cnt + 1'b1;
                    end
                end
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    ecc_43_cal i_ecc_43_cal (
        .data_in   (rd_word.fields.data),
        .parity_in (rd_word.fields.parity),
        .bypass    (bypass),
        .data_out  (cal_data),
        .sbit_err  (cal_sbit_err),
        .dbit_err  (cal_dbit_err)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid    <= 1'b0;
            out_sbit_err <= 1'b0;
            out_dbit_err <= 1'b0;
        end else begin
            out_valid    <= rd_pop;
            // flags only mean something alongside out_valid.
            out_sbit_err <= rd_pop && cal_sbit_err;
            out_dbit_err <= rd_pop && cal_dbit_err;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pop) begin
            out_data <= cal_data;
        end
    end

endmodule

// ==== rtl/ecc_word_buffer.sv ====
`timescale 1ns/1ns

module ecc_word_buffer (
    input  logic               clk,
    input  logic               reset,
    input  logic               wr_valid,
    input  ecc_pkg::ecc_word_t wr_word,
    input  logic               rd_pop,
    output logic               rd_avail,
    output ecc_pkg::ecc_word_t rd_word,
    output logic               in_credit
);
    import ecc_pkg::*;

    ecc_word_t              mem [BUF_DEPTH];
    logic [PTR_WIDTH-1:0]   wr_ptr;
    logic [PTR_WIDTH-1:0]   rd_ptr;
    logic [COUNT_WIDTH-1:0] count;

    // sender credits guarantee a free slot, so every write is taken.
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            mem[wr_ptr] <= wr_word;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
        end else if (wr_valid) begin
            if (wr_ptr == PTR_WIDTH'(BUF_DEPTH - 1)) begin
                wr_ptr <= '0;
            end else begin
                wr_ptr <= wr_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr <= '0;
        end else if (rd_pop) begin
            if (rd_ptr == PTR_WIDTH'(BUF_DEPTH - 1)) begin
                rd_ptr <= '0;
            end else begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            case ({wr_valid, rd_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one slot freed per pop, returned to the sender a cycle later.
    always_ff @(posedge clk) begin
        if (reset) begin
            in_credit <= 1'b0;
        end else begin
            in_credit <= rd_pop;
        end
    end

    assign rd_avail = (count != '0);
    assign rd_word  = mem[rd_ptr];

endmodule

// ==== rtl/ecc_write_encoder.sv ====
`timescale 1ns/1ns

module ecc_write_encoder (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           in_valid,
    input  logic [ecc_pkg::DATA_WIDTH-1:0] in_data,
    input  logic [ecc_pkg::CODE_WIDTH-1:0] in_flip,
    output logic                           wr_valid,
    output ecc_pkg::ecc_word_t             wr_word
);
    import ecc_pkg::*;

    ecc_word_t code;

    always_comb begin
        code.fields.data   = in_data;
        code.fields.parity = ecc_encode(in_data);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= in_valid;
        end
    end

    // diagnostic flips land on the whole codeword, parity included.
    always_ff @(posedge clk) begin
        if (in_valid) begin
            wr_word.bits <= code.bits ^ in_flip;
        end
    end

endmodule

// ==== verif/ecc_buffer_properties.sv ====
`timescale 1ns/1ns

module ecc_buffer_properties (
    input logic                               clk,
    input logic                               reset,
    input logic                               rd_avail,
    input logic                               rd_pop,
    input logic                               out_valid,
    input logic                               out_sbit_err,
    input logic                               out_dbit_err,
    input logic [ecc_pkg::CREDIT_WIDTH-1:0]   credit_cnt
);

    flags_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(out_sbit_err && out_dbit_err))
        else $error("single and double error flags high together");

    flags_need_valid: assert property (@(posedge clk) disable iff (reset)
        (out_sbit_err || out_dbit_err) |-> out_valid)
        else $error("error flag high without out_valid");

    // output is registered from the pop, so look at the credit one cycle back.
    valid_needs_credit: assert property (@(posedge clk) disable iff (reset)
        $rose(out_valid) |-> ($past(credit_cnt) != '0))
        else $error("out_valid rose with no output credit");

    pop_needs_avail: assert property (@(posedge clk) disable iff (reset)
        rd_pop |-> rd_avail)
        else $error("rd_pop without rd_avail");

endmodule

bind ecc_read_corrector ecc_buffer_properties i_ecc_buffer_properties (
    .clk          (clk),
    .reset        (reset),
    .rd_avail     (rd_avail),
    .rd_pop       (rd_pop),
    .out_valid    (out_valid),
    .out_sbit_err (out_sbit_err),
    .out_dbit_err (out_dbit_err),
    .credit_cnt   (credit_cnt)
);

// ==== verif/ecc_buffer_tb.sv ====
`timescale 1ns/1ns

module ecc_buffer_tb;
    import ecc_pkg::*;

    localparam int CLEAN_WORDS  = 200;
    localparam int SINGLE_WORDS = 120;
    localparam int DOUBLE_WORDS = 120;
    localparam int BYPASS_WORDS = 90;
    localparam int BP_WORDS     = 40;
    localparam int RESET_WORDS  = 50;
    localparam int TOTAL_WORDS  = CLEAN_WORDS + SINGLE_WORDS + DOUBLE_WORDS
                                + BYPASS_WORDS + BP_WORDS + RESET_WORDS;
    localparam int HOLD_CYCLES  = 60;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic                  sbit;
        logic                  dbit;
    } expect_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  in_valid;
    logic [DATA_WIDTH-1:0] in_data;
    logic [CODE_WIDTH-1:0] in_flip;
    logic                  in_credit;
    logic                  out_credit;
    logic                  bypass;
    logic                  out_valid;
    logic [DATA_WIDTH-1:0] out_data;
    logic                  out_sbit_err;
    logic                  out_dbit_err;

    integer  seed;
    expect_t exp_q [$];
    int      send_credits;
    int      words_left;
    int      flip_mode;
    int      owed;
    logic    hold_credits;
    int      errors;
    int      words_checked;
    int      out_words;
    int      credit_pulses;
    int      tests_done;
    int      errors_mark;
    int      words_mark;

    ecc_buffer_top i_ecc_buffer_top (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_data      (in_data),
        .in_flip      (in_flip),
        .in_credit    (in_credit),
        .out_credit   (out_credit),
        .bypass       (bypass),
        .out_valid    (out_valid),
        .out_data     (out_data),
        .out_sbit_err (out_sbit_err),
        .out_dbit_err (out_dbit_err)
    );

    always #50 clk = ~clk;

    task automatic check_data(input logic [DATA_WIDTH-1:0] got,
                              input logic [DATA_WIDTH-1:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %h got %h", $time, what, exp, got);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t ns: %s expected %b got %b", $time, what, exp, got);
        end
    endtask

    function automatic int pick_bit();
        return int'($unsigned($random(seed)) % CODE_WIDTH);
    endfunction

    // n distinct flipped positions anywhere in the codeword.
    function automatic logic [CODE_WIDTH-1:0] make_flip(input int n);
        logic [CODE_WIDTH-1:0] flip;
        int                    first;
        int                    second;
        flip   = '0;
        first  = pick_bit();
        second = pick_bit();
        while (second == first) begin
            second = pick_bit();
        end
        if (n >= 1) begin
            flip[first] = 1'b1;
        end
        if (n >= 2) begin
            flip[second] = 1'b1;
        end
        return flip;
    endfunction

    task automatic check_output();
        expect_t exp;
        if (exp_q.size() == 0) begin
            errors++;
            $display("error at %0t ns: output word arrived with no word outstanding", $time);
        end else begin
            exp = exp_q.pop_front();
            check_data(out_data, exp.data, "out_data");
            check_flag(out_sbit_err, exp.sbit, "out_sbit_err");
            check_flag(out_dbit_err, exp.dbit, "out_dbit_err");
            words_checked++;
        end
    endtask

    // one clock of sender, receiver and output checking, all on the falling edge.
    task automatic step();
        logic [63:0]           raw;
        logic [DATA_WIDTH-1:0] data;
        logic [CODE_WIDTH-1:0] flip;
        logic [CODE_WIDTH-1:0] code;
        expect_t               exp;
        int                    nflips;
        @(negedge clk);
        if (in_credit) begin
            credit_pulses++;
            if (send_credits == BUF_DEPTH) begin
                errors++;
                $display("error at %0t ns: in_credit pulse while all credits were held",
                         $time);
            end else begin
                send_credits++;
            end
        end
        if (out_valid) begin
            out_words++;
            owed++;
            check_output();
        end
        out_credit = 1'b0;
        if (owed > 0 && !hold_credits && ($random(seed) & 1) == 0) begin
            out_credit = 1'b1;
            owed--;
        end
        in_valid = 1'b0;
        in_data  = '0;
        in_flip  = '0;
        if (words_left > 0 && send_credits > 0 && ($random(seed) & 3) != 0) begin
            raw  = {$random(seed), $random(seed)};
            data = raw[DATA_WIDTH-1:0];
            case (flip_mode)
                0:       nflips = 0;
                1:       nflips = 1;
                2:       nflips = 2;
                default: nflips = int'($unsigned($random(seed)) % 3);
            endcase
            flip = make_flip(nflips);
            code = {ecc_encode(data), data} ^ flip;
            if (bypass || nflips == 2) begin
                exp.data = code[DATA_WIDTH-1:0];
            end else begin
                exp.data = data;
            end
            exp.sbit = !bypass && nflips == 1;
            exp.dbit = !bypass && nflips == 2;
            exp_q.push_back(exp);
            in_valid = 1'b1;
            in_data  = data;
            in_flip  = flip;
            send_credits--;
            words_left--;
        end
    endtask

    task automatic drain();
        while (words_left > 0 || exp_q.size() > 0 || owed > 0) begin
            step();
        end
        if (send_credits != BUF_DEPTH) begin
            errors++;
            $display("error at %0t ns: sender holds %0d credits after drain, not %0d",
                     $time, send_credits, BUF_DEPTH);
        end
    endtask

    task automatic run_words(input int n, input int mode);
        flip_mode  = mode;
        words_left = n;
        drain();
    endtask

    task automatic apply_reset(input int cycles);
        reset      = 1'b1;
        in_valid   = 1'b0;
        in_data    = '0;
        in_flip    = '0;
        out_credit = 1'b0;
        repeat (cycles) @(negedge clk);
        check_flag(out_valid, 1'b0, "out_valid in reset");
        check_flag(out_sbit_err, 1'b0, "out_sbit_err in reset");
        check_flag(out_dbit_err, 1'b0, "out_dbit_err in reset");
        check_flag(in_credit, 1'b0, "in_credit in reset");
        reset = 1'b0;
        exp_q.delete();
        owed         = 0;
        words_left   = 0;
        send_credits = BUF_DEPTH;
    endtask

    task automatic back_pressure();
        int outs_mark;
        int pulses_mark;
        hold_credits = 1'b1;
        flip_mode    = 0;
        words_left   = BP_WORDS;
        outs_mark    = out_words;
        repeat (HOLD_CYCLES / 2) step();
        pulses_mark = credit_pulses;
        repeat (HOLD_CYCLES / 2) step();
        if (out_words - outs_mark > OUT_CREDITS) begin
            errors++;
            $display("error at %0t ns: %0d words left during the stall, limit is %0d",
                     $time, out_words - outs_mark, OUT_CREDITS);
        end
        if (credit_pulses != pulses_mark) begin
            errors++;
            $display("error at %0t ns: in_credit kept pulsing while output was stalled", $time);
        end
        if (send_credits != 0) begin
            errors++;
            $display("error at %0t ns: sender still had credits during the stall", $time);
        end
        hold_credits = 1'b0;
        drain();
    endtask

    task automatic reset_mid_traffic();
        flip_mode  = 3;
        words_left = RESET_WORDS - 20;
        repeat (15) step();
        apply_reset(4);
        run_words(20, 3);
    endtask

    task automatic report_test(input string name);
        tests_done++;
        $display("test %-18s words %4d  errors %0d", name, words_checked - words_mark,
                 errors - errors_mark);
        words_mark  = words_checked;
        errors_mark = errors;
    endtask

    initial begin
        seed          = 32'hcad9_d6b4;
        reset         = 1'b1;
        in_valid      = 1'b0;
        in_data       = '0;
        in_flip       = '0;
        out_credit    = 1'b0;
        bypass        = 1'b0;
        hold_credits  = 1'b0;
        flip_mode     = 0;
        errors        = 0;
        words_checked = 0;
        out_words     = 0;
        credit_pulses = 0;
        tests_done    = 0;
        errors_mark   = 0;
        words_mark    = 0;
        apply_reset(10);

        run_words(CLEAN_WORDS, 0);
        report_test("clean traffic");
        run_words(SINGLE_WORDS, 1);
        report_test("single-bit fix");
        run_words(DOUBLE_WORDS, 2);
        report_test("double-bit detect");
        // bypass only changes with the buffer empty.
        bypass = 1'b1;
        run_words(BYPASS_WORDS, 3);
        bypass = 1'b0;
        report_test("bypass");
        back_pressure();
        report_test("back-pressure");
        reset_mid_traffic();
        report_test("reset state");

        $display("summary: %0d tests, %0d words checked, %0d errors",
                 tests_done, words_checked, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // a word never needs close to 20 cycles, even through the stall.
    initial begin
        repeat (TOTAL_WORDS * 20) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", TOTAL_WORDS * 20);
        $display("Regression failed");
        $finish;
    end

endmodule
